// ==== common/rv_defines.svh ====
// ******************************
// widths, reset vector and halt
// constants for the rv32i core
// ******************************
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath and register file
`define XLEN 32
`define REG_COUNT 32

// program counter
`define RESET_PC 0
`define PC_STEP 4

// ecall halt convention, a7 holds the service code
`define HALT_REG 17
`define HALT_CODE 10

// cycles from halt request until is_halted
`define DRAIN_CYCLES 3

`endif

// ==== common/rv_pkg.sv ====
// ******************************
// shared types for the core
// words, register indices,
// opcodes, alu ops, fwd selects
// ******************************
`include "rv_defines.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

  // major opcodes still decoded
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_system = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_pass_zero // bubbles and unknown encodings
  } alu_op_t;

  // operand source in execute
  typedef enum logic [1:0] {
    fwd_reg,    // value read in decode
    fwd_ex_mem, // result one stage ahead
    fwd_wb,     // value being written back
    fwd_late    // value written back a cycle earlier
  } fwd_sel_t;

endpackage

// ==== execute/alu.sv ====
// ******************************
// integer alu
// add sub and or xor sll srl
// ******************************
`timescale 1ns/100ps

module alu
  import rv_pkg::*;
(
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // rv32 shifts use the low five bits

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_or: begin
        result = a | b;
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_srl: begin
        result = a >> shamt; // logical, zero fill
      end
      default: begin
        result = '0; // pass_zero
      end
    endcase
  end

endmodule

// ==== decode/register_file.sv ====
// ******************************
// 32 x 32-bit register file
// x0 reads as zero
// ******************************
`timescale 1ns/100ps
`include "rv_defines.svh"

module register_file
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  input  logic     write,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // same-cycle write is not visible here, execute covers it
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/fetch_stage.sv ====
// ******************************
// fetch stage
// pc with stall hold, if/id reg
// ******************************
`timescale 1ns/100ps
`include "rv_defines.svh"

module fetch_stage
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,
  input  word_t imem_data,
  output word_t imem_addr,
  output word_t if_inst
);

  word_t pc;

  assign imem_addr = pc; // imem answers in the same cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= word_t'(`RESET_PC);
    end else if (!stall) begin
      pc <= pc + word_t'(`PC_STEP);
    end
  end

  // cleared to an all-zero word, which decodes to a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      if_inst <= '0;
    end else if (!stall) begin
      if_inst <= imem_data;
    end
  end

  pc_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(pc));

endmodule

// ==== decode/decode_stage.sv ====
// ******************************
// decode stage
// control decode, immediates,
// load-use and halt stall,
// register file, id/ex regs
// ******************************
`timescale 1ns/100ps
`include "rv_defines.svh"

module decode_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  word_t    if_inst,
  input  logic     halt_req,
  input  reg_idx_t wb_rd,
  input  word_t    wb_data,
  input  logic     wb_write,
  output logic     stall,
  output reg_idx_t id_rs1,
  output reg_idx_t id_rs2,
  output word_t    id_rs1_data,
  output word_t    id_rs2_data,
  output word_t    id_imm,
  output reg_idx_t id_rd,
  output alu_op_t  id_alu_op,
  output logic     id_alu_src,
  output logic     id_mem_read,
  output logic     id_mem_write,
  output logic     id_reg_write,
  output logic     id_is_ecall
);

  opcode_t  opcode;
  logic [2:0] funct3;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    imm;
  alu_op_t  alu_op;
  logic     alu_src, mem_read, mem_write, reg_write, is_ecall;
  logic     uses_rs1, uses_rs2;
  logic     load_use;
  logic     halt_seen;

  assign opcode = opcode_t'(if_inst[6:0]);
  assign funct3 = if_inst[14:12];
  assign rs2    = if_inst[24:20];
  assign rs1    = is_ecall ? reg_idx_t'(`HALT_REG) : if_inst[19:15]; // ecall reads a7

  always_comb begin
    alu_op    = alu_pass_zero;
    alu_src   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    is_ecall  = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    case (opcode)
      opc_op, opc_op_imm: begin
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = (opcode == opc_op);
        alu_src   = (opcode == opc_op_imm);
        case (funct3)
          3'b000:  alu_op = (opcode == opc_op && if_inst[30]) ? alu_sub : alu_add;
          3'b111:  alu_op = alu_and;
          3'b110:  alu_op = alu_or;
          3'b100:  alu_op = alu_xor;
          3'b001:  alu_op = alu_sll;
          3'b101:  alu_op = if_inst[30] ? alu_pass_zero : alu_srl; // no sra
          default: alu_op = alu_pass_zero;
        endcase
      end
      opc_load: begin
        alu_op    = alu_add; // address = rs1 + imm
        alu_src   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
      end
      opc_store: begin
        alu_op    = alu_add;
        alu_src   = 1'b1;
        mem_write = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
      end
      opc_system: begin
        is_ecall = (funct3 == 3'b000);
        uses_rs1 = is_ecall;
      end
      default: ;
    endcase
  end

  // sign-extended I and S immediates
  assign imm = (opcode == opc_store) ?
               {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]} :
               {{20{if_inst[31]}}, if_inst[31:20]};

  // loaded value not ready until mem, one bubble covers it
  assign load_use = id_mem_read && (id_rd != '0) &&
                    ((uses_rs1 && rs1 == id_rd) || (uses_rs2 && rs2 == id_rd));

  assign stall = load_use || halt_req || halt_seen;

  always_ff @(posedge clk) begin
    if (reset) begin
      halt_seen <= 1'b0;
    end else if (halt_req) begin
      halt_seen <= 1'b1; // sticky until reset
    end
  end

  register_file u_regs (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .write    (wb_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // id/ex control, a stall turns it into a bubble
  always_ff @(posedge clk) begin
    if (reset || stall) begin
      id_alu_op    <= alu_pass_zero;
      id_alu_src   <= 1'b0;
      id_mem_read  <= 1'b0;
      id_mem_write <= 1'b0;
      id_reg_write <= 1'b0;
      id_is_ecall  <= 1'b0;
    end else begin
      id_alu_op    <= alu_op;
      id_alu_src   <= alu_src;
      id_mem_read  <= mem_read;
      id_mem_write <= mem_write;
      id_reg_write <= reg_write;
      id_is_ecall  <= is_ecall;
    end
  end

  // id/ex payload
  always_ff @(posedge clk) begin
    id_rs1      <= rs1;
    id_rs2      <= rs2;
    id_rs1_data <= rs1_data;
    id_rs2_data <= rs2_data;
    id_imm      <= imm;
    id_rd       <= if_inst[11:7];
  end

  bubble_is_inert: assert property (@(posedge clk) disable iff (reset)
    stall |=> !id_reg_write && !id_mem_write && !id_mem_read && !id_is_ecall);

endmodule

// ==== execute/execute_stage.sv ====
// ******************************
// execute stage
// forwarding, operand muxes,
// late writeback reg, halt check,
// ex/mem registers
// ******************************
`timescale 1ns/100ps
`include "rv_defines.svh"

module execute_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  reg_idx_t id_rs1,
  input  reg_idx_t id_rs2,
  input  word_t    id_rs1_data,
  input  word_t    id_rs2_data,
  input  word_t    id_imm,
  input  reg_idx_t id_rd,
  input  alu_op_t  id_alu_op,
  input  logic     id_alu_src,
  input  logic     id_mem_read,
  input  logic     id_mem_write,
  input  logic     id_reg_write,
  input  logic     id_is_ecall,
  input  reg_idx_t wb_rd,
  input  word_t    wb_data,
  input  logic     wb_write,
  output logic     halt_req,
  output word_t    ex_result,
  output word_t    ex_store_data,
  output reg_idx_t ex_rd,
  output logic     ex_mem_read,
  output logic     ex_mem_write,
  output logic     ex_reg_write
);

  reg_idx_t late_rd;
  word_t    late_data;
  logic     late_write;
  fwd_sel_t fwd_a, fwd_b;
  word_t    op_a, op_b_reg, op_b;
  word_t    alu_out;

  // nearest producer wins
  function automatic fwd_sel_t pick_src(input reg_idx_t rs);
    fwd_sel_t sel;
    sel = fwd_reg;
    if (rs != '0) begin
      if (ex_reg_write && rs == ex_rd)
        sel = fwd_ex_mem;
      else if (wb_write && rs == wb_rd)
        sel = fwd_wb;
      else if (late_write && rs == late_rd)
        sel = fwd_late;
    end
    return sel;
  endfunction

  function automatic word_t fwd_value(input fwd_sel_t sel, input word_t reg_val);
    word_t val;
    case (sel)
      fwd_ex_mem: val = ex_result;
      fwd_wb:     val = wb_data;
      fwd_late:   val = late_data;
      default:    val = reg_val;
    endcase
    return val;
  endfunction

  always_comb begin
    fwd_a    = pick_src(id_rs1);
    fwd_b    = pick_src(id_rs2);
    op_a     = fwd_value(fwd_a, id_rs1_data);
    op_b_reg = fwd_value(fwd_b, id_rs2_data);
  end

  assign op_b = id_alu_src ? id_imm : op_b_reg;

  alu u_alu (
    .op     (id_alu_op),
    .a      (op_a),
    .b      (op_b),
    .result (alu_out)
  );

  // ecall in ex, a7 after forwarding
  assign halt_req = id_is_ecall && (op_a == word_t'(`HALT_CODE));

  // writeback seen while the current id/ex entry was still in decode
  always_ff @(posedge clk) begin
    if (reset) begin
      late_write <= 1'b0;
    end else if (!stall) begin
      late_write <= wb_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      late_rd   <= wb_rd;
      late_data <= wb_data;
    end
  end

  // ex/mem
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
    end else begin
      ex_mem_read  <= id_mem_read;
      ex_mem_write <= id_mem_write;
      ex_reg_write <= id_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    ex_result     <= alu_out;
    ex_store_data <= op_b_reg; // forwarded rs2
    ex_rd         <= id_rd;
  end

endmodule

// ==== src/mem_wb_stage.sv ====
// ******************************
// mem/wb stage
// mem/wb regs, writeback select,
// halt drain counter
// ******************************
`timescale 1ns/100ps
`include "rv_defines.svh"

module mem_wb_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     halt_req,
  input  word_t    ex_result,
  input  reg_idx_t ex_rd,
  input  logic     ex_mem_read,
  input  logic     ex_reg_write,
  input  word_t    dmem_rdata,
  output reg_idx_t wb_rd,
  output word_t    wb_data,
  output logic     wb_write,
  output logic     is_halted
);

  localparam int drain_w = $clog2(`DRAIN_CYCLES + 1);

  word_t wb_result;
  word_t wb_load;
  logic  wb_is_load;
  logic [drain_w-1:0] drain_count;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_write   <= 1'b0;
      wb_is_load <= 1'b0;
    end else begin
      wb_write   <= ex_reg_write;
      wb_is_load <= ex_mem_read;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd     <= ex_rd;
    wb_result <= ex_result;
    wb_load   <= dmem_rdata;
  end

  assign wb_data = wb_is_load ? wb_load : wb_result;

  // lets older instructions leave the pipe before halting
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_count <= '0;
      is_halted   <= 1'b0;
    end else if (!is_halted && (halt_req || drain_count != '0)) begin
      if (drain_count == drain_w'(`DRAIN_CYCLES - 1)) begin
        is_halted <= 1'b1;
      end
      drain_count <= drain_count + 1'b1;
    end
  end

  halted_is_sticky: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> is_halted);

endmodule

// ==== src/rv_core.sv ====
// ******************************
// five-stage rv32i core top
// stage instances and external
// instruction/data memory ports
// ******************************
`timescale 1ns/100ps

module rv_core
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  word_t imem_data,
  input  word_t dmem_rdata,
  output word_t imem_addr,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output logic  dmem_read,
  output logic  dmem_write,
  output logic  is_halted
);

  word_t    if_inst;
  logic     stall;
  logic     halt_req;

  // id/ex outputs
  reg_idx_t id_rs1;
  reg_idx_t id_rs2;
  word_t    id_rs1_data;
  word_t    id_rs2_data;
  word_t    id_imm;
  reg_idx_t id_rd;
  alu_op_t  id_alu_op;
  logic     id_alu_src;
  logic     id_mem_read;
  logic     id_mem_write;
  logic     id_reg_write;
  logic     id_is_ecall;

  reg_idx_t ex_rd;
  logic     ex_reg_write;

  // writeback bus, shared by regfile and forwarding
  reg_idx_t wb_rd;
  word_t    wb_data;
  logic     wb_write;

  fetch_stage u_fetch (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .if_inst   (if_inst)
  );

  decode_stage u_decode (
    .clk          (clk),
    .reset        (reset),
    .if_inst      (if_inst),
    .halt_req     (halt_req),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .wb_write     (wb_write),
    .stall        (stall),
    .id_rs1       (id_rs1),
    .id_rs2       (id_rs2),
    .id_rs1_data  (id_rs1_data),
    .id_rs2_data  (id_rs2_data),
    .id_imm       (id_imm),
    .id_rd        (id_rd),
    .id_alu_op    (id_alu_op),
    .id_alu_src   (id_alu_src),
    .id_mem_read  (id_mem_read),
    .id_mem_write (id_mem_write),
    .id_reg_write (id_reg_write),
    .id_is_ecall  (id_is_ecall)
  );

  // ex/mem result and store data drive the data memory directly
  execute_stage u_execute (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .id_rs1        (id_rs1),
    .id_rs2        (id_rs2),
    .id_rs1_data   (id_rs1_data),
    .id_rs2_data   (id_rs2_data),
    .id_imm        (id_imm),
    .id_rd         (id_rd),
    .id_alu_op     (id_alu_op),
    .id_alu_src    (id_alu_src),
    .id_mem_read   (id_mem_read),
    .id_mem_write  (id_mem_write),
    .id_reg_write  (id_reg_write),
    .id_is_ecall   (id_is_ecall),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .wb_write      (wb_write),
    .halt_req      (halt_req),
    .ex_result     (dmem_addr),
    .ex_store_data (dmem_wdata),
    .ex_rd         (ex_rd),
    .ex_mem_read   (dmem_read),
    .ex_mem_write  (dmem_write),
    .ex_reg_write  (ex_reg_write)
  );

  mem_wb_stage u_mem_wb (
    .clk          (clk),
    .reset        (reset),
    .halt_req     (halt_req),
    .ex_result    (dmem_addr),
    .ex_rd        (ex_rd),
    .ex_mem_read  (dmem_read),
    .ex_reg_write (ex_reg_write),
    .dmem_rdata   (dmem_rdata),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .wb_write     (wb_write),
    .is_halted    (is_halted)
  );

endmodule

// ==== testbench/tb_model.svh ====
// ******************************
// testbench model
// lfsr, instruction encoders,
// program builders and the
// isa-level reference run
// ******************************
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1
function automatic logic lfsr_step();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic word_t rand_bits(input int n);
  word_t v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_step()}; // one step per bit
  end
  return v;
endfunction

function automatic void emit(input word_t w);
  prog[prog_len] = w;
  prog_len++;
endfunction

function automatic void emit_r(input logic [2:0] f3, input logic [6:0] f7,
                               input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [4:0] rs2);
  emit({f7, rs2, rs1, f3, rd, 7'b0110011});
endfunction

function automatic void emit_i(input logic [2:0] f3, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [11:0] imm);
  emit({imm, rs1, f3, rd, 7'b0010011});
endfunction

// loads and stores use x0 as base, the address is the immediate
function automatic void emit_lw(input logic [4:0] rd, input logic [11:0] imm);
  emit({imm, 5'd0, 3'b010, rd, 7'b0000011});
endfunction

function automatic void emit_sw(input logic [4:0] rs2, input logic [11:0] imm);
  emit({imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011});
endfunction

function automatic void emit_pad(input int n);
  for (int i = 0; i < n; i++) begin
    emit_i(3'd0, 5'd0, 5'd0, 12'd0); // nop
  end
endfunction

// dump every register, then the halting ecall
function automatic void emit_tail();
  for (int i = 1; i < 32; i++) begin
    emit_sw(5'(i), 12'h200 + 12'(4 * i));
  end
  emit_i(3'd0, 5'd17, 5'd0, 12'(`HALT_CODE));
  emit(32'h00000073);
endfunction

function automatic void build_random(input int count);
  logic [2:0] r_f3 [7];
  logic [2:0] i_f3 [6];
  int k;
  r_f3 = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5}; // second is sub
  i_f3 = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5};
  for (int n = 0; n < count; n++) begin
    case (rand_bits(2))
      0, 1: begin
        k = int'(rand_bits(3)) % 7;
        emit_r(r_f3[k], (k == 1) ? 7'h20 : 7'h00, 5'(rand_bits(5)),
               5'(rand_bits(5)), 5'(rand_bits(5)));
      end
      2: begin
        k = int'(rand_bits(3)) % 6;
        if (k >= 4)
          emit_i(i_f3[k], 5'(rand_bits(5)), 5'(rand_bits(5)), 12'(rand_bits(5)));
        else
          emit_i(i_f3[k], 5'(rand_bits(5)), 5'(rand_bits(5)), 12'(rand_bits(12)));
      end
      default: begin
        if (rand_bits(1) == 1'b1)
          emit_lw(5'(rand_bits(5)), 12'h100 + 12'(4 * rand_bits(6)));
        else
          emit_sw(5'(rand_bits(5)), 12'h100 + 12'(4 * rand_bits(6)));
      end
    endcase
  end
endfunction

// runs prog at isa level, queues every load address and store in order
function automatic void run_reference();
  word_t r [32];
  word_t mem [1024];
  word_t w, a, b, res, addr;
  logic [2:0] f3;
  for (int i = 0; i < 32; i++) r[i] = '0;
  for (int i = 0; i < 1024; i++) mem[i] = fill_word(i);
  exp_addr.delete();
  exp_data.delete();
  exp_load_addr.delete();
  for (int pc = 0; pc < prog_len; pc++) begin
    w  = prog[pc];
    f3 = w[14:12];
    a  = r[w[19:15]];
    b  = (w[6:0] == 7'h33) ? r[w[24:20]] : {{20{w[31]}}, w[31:20]};
    case (f3)
      3'd0:    res = (w[6:0] == 7'h33 && w[30]) ? a - b : a + b;
      3'd7:    res = a & b;
      3'd6:    res = a | b;
      3'd4:    res = a ^ b;
      3'd1:    res = a << b[4:0];
      default: res = a >> b[4:0];
    endcase
    case (w[6:0])
      7'h33, 7'h13: r[w[11:7]] = res;
      7'h03: begin
        addr = a + {{20{w[31]}}, w[31:20]};
        r[w[11:7]] = mem[addr[11:2]];
        exp_load_addr.push_back(addr);
      end
      7'h23: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        mem[addr[11:2]] = r[w[24:20]];
        exp_addr.push_back(addr);
        exp_data.push_back(r[w[24:20]]);
      end
      default: ;
    endcase
    r[0] = '0;
    if (w == 32'h00000073 && r[17] == word_t'(`HALT_CODE)) break;
  end
endfunction

`endif

// ==== testbench/tb_rv_core.sv ====
// ******************************
// testbench for rv_core
// clock, reset, memory models,
// store monitor, watchdog and
// directed and random programs
// ******************************
`timescale 1ns/100ps
`include "rv_defines.svh"

module tb_rv_core
  import rv_pkg::*;
();

  localparam int num_tests = 44;
  localparam int prog_max  = 128;
  localparam int watchdog_cycles = num_tests * (2 * prog_max + 60);

  logic  clk;
  logic  reset;
  word_t imem_data, dmem_rdata, imem_addr, dmem_addr, dmem_wdata;
  logic  dmem_read, dmem_write, is_halted;

  word_t imem [256];
  word_t dmem [1024];
  word_t prog [prog_max];
  int    prog_len;
  word_t exp_addr [$];
  word_t exp_data [$];
  word_t exp_load_addr [$];
  logic [31:0] lfsr_state = 32'he076;
  int    test_errors;
  int    tests_passed;
  int    tests_failed;

  function automatic word_t fill_word(input int i);
    return (word_t'(i) * 32'h9e3779b1) ^ 32'h5a5a0f0f; // spread over all address bits
  endfunction

  `include "tb_model.svh"

  rv_core uut (
    .clk        (clk),
    .reset      (reset),
    .imem_data  (imem_data),
    .dmem_rdata (dmem_rdata),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .is_halted  (is_halted)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[11:2]];

  always @(posedge clk) begin
    if (dmem_write) dmem[dmem_addr[11:2]] <= dmem_wdata;
  end

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  // stores and loads checked mid-cycle, against the reference order
  always @(negedge clk) begin
    if (!reset && dmem_write) begin
      compare_bit("is_halted", is_halted, 1'b0);
      if (exp_addr.size() == 0) begin
        $display("at %0t: store to %h that the reference does not make", $time, dmem_addr);
        test_errors++;
      end else begin
        compare_word("dmem_addr", dmem_addr, exp_addr.pop_front());
        compare_word("dmem_wdata", dmem_wdata, exp_data.pop_front());
      end
    end
    if (!reset && dmem_read) begin
      if (exp_load_addr.size() == 0) begin
        $display("at %0t: load from %h that the reference does not make", $time, dmem_addr);
        test_errors++;
      end else begin
        compare_word("dmem_addr", dmem_addr, exp_load_addr.pop_front());
      end
    end
  end

  task automatic run_program(input string name);
    int cycles;
    int limit;
    @(posedge clk);
    reset <= 1'b1;
    for (int i = 0; i < 256; i++) imem[i] = (i < prog_len) ? prog[i] : '0;
    for (int i = 0; i < 1024; i++) dmem[i] = fill_word(i);
    run_reference();
    test_errors = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    cycles = 0;
    limit  = 2 * prog_len + 60;
    @(negedge clk);
    while (!is_halted && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!is_halted) begin
      $display("%s: core did not halt within %0d cycles", name, limit);
      test_errors++;
    end else if (exp_addr.size() != 0 || exp_load_addr.size() != 0) begin
      $display("%s: halted with %0d stores and %0d loads still missing", name,
               exp_addr.size(), exp_load_addr.size());
      test_errors++;
    end
    repeat (8) @(negedge clk);
    compare_bit("is_halted", is_halted, 1'b1);
    if (test_errors == 0) begin
      $display("test %s: pass", name);
      tests_passed++;
    end else begin
      $display("test %s: fail, %0d errors", name, test_errors);
      tests_failed++;
    end
  endtask

  initial begin
    #(watchdog_cycles * 20);
    $display("watchdog timeout, the tests did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    reset = 1'b1;
    tests_passed = 0;
    tests_failed = 0;

    prog_len = 0; // operations with nops between, no hazards
    emit_i(3'd0, 5'd1, 5'd0, 12'h5a3);
    emit_i(3'd0, 5'd2, 5'd0, 12'hedd);
    emit_i(3'd0, 5'd3, 5'd0, 12'd13);
    emit_pad(3);
    emit_r(3'd0, 7'h00, 5'd4, 5'd1, 5'd2);
    emit_pad(3);
    emit_r(3'd0, 7'h20, 5'd5, 5'd1, 5'd2);
    emit_pad(3);
    emit_r(3'd7, 7'h00, 5'd6, 5'd1, 5'd2);
    emit_pad(3);
    emit_r(3'd6, 7'h00, 5'd7, 5'd1, 5'd2);
    emit_pad(3);
    emit_r(3'd4, 7'h00, 5'd8, 5'd1, 5'd2);
    emit_pad(3);
    emit_r(3'd1, 7'h00, 5'd9, 5'd1, 5'd3);
    emit_pad(3);
    emit_r(3'd5, 7'h00, 5'd10, 5'd2, 5'd3);
    emit_pad(3);
    emit_i(3'd0, 5'd11, 5'd1, 12'hffb);
    emit_pad(3);
    emit_i(3'd7, 5'd12, 5'd2, 12'h0f0);
    emit_pad(3);
    emit_i(3'd6, 5'd13, 5'd1, 12'h700);
    emit_pad(3);
    emit_i(3'd4, 5'd14, 5'd2, 12'hfff);
    emit_pad(3);
    emit_i(3'd1, 5'd15, 5'd1, 12'd20);
    emit_pad(3);
    emit_i(3'd5, 5'd16, 5'd2, 12'd7);
    emit_pad(3);
    emit_tail();
    run_program("alu_ops");

    prog_len = 0; // dependencies at distance 1, 2 and 3
    emit_i(3'd0, 5'd1, 5'd0, 12'd7);
    emit_i(3'd0, 5'd2, 5'd1, 12'd3);
    emit_r(3'd0, 7'h00, 5'd3, 5'd2, 5'd1);
    emit_r(3'd0, 7'h20, 5'd4, 5'd3, 5'd1);
    emit_r(3'd4, 7'h00, 5'd5, 5'd1, 5'd4);
    emit_i(3'd1, 5'd6, 5'd3, 12'd4);
    emit_sw(5'd6, 12'h100);
    emit_r(3'd6, 7'h00, 5'd7, 5'd6, 5'd5);
    emit_r(3'd0, 7'h00, 5'd7, 5'd7, 5'd7);
    emit_tail();
    run_program("forwarding");

    prog_len = 0; // load-use and read back
    emit_i(3'd0, 5'd1, 5'd0, 12'h321);
    emit_sw(5'd1, 12'h100);
    emit_lw(5'd5, 12'h100);
    emit_r(3'd0, 7'h00, 5'd6, 5'd5, 5'd5);
    emit_lw(5'd7, 12'h140);
    emit_r(3'd4, 7'h00, 5'd8, 5'd7, 5'd6);
    emit_sw(5'd8, 12'h104);
    emit_lw(5'd9, 12'h104);
    emit_sw(5'd9, 12'h108);
    emit_lw(5'd10, 12'h108);
    emit_i(3'd0, 5'd11, 5'd10, 12'd1);
    emit_tail();
    run_program("load_use");

    prog_len = 0; // ecalls without the halt code
    emit_i(3'd0, 5'd17, 5'd0, 12'd3);
    emit(32'h00000073);
    emit_i(3'd0, 5'd18, 5'd17, 12'd5);
    emit_i(3'd0, 5'd17, 5'd0, 12'd9);
    emit(32'h00000073);
    emit_i(3'd0, 5'd19, 5'd0, 12'd1);
    emit_tail();
    run_program("early_ecall");

    for (int t = 0; t < 40; t++) begin
      prog_len = 0;
      build_random(30);
      emit_tail();
      run_program($sformatf("random_%0d", t));
    end

    $display("tests run %0d, passed %0d, failed %0d",
             tests_passed + tests_failed, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+common
+incdir+testbench
common/rv_pkg.sv
execute/alu.sv
decode/register_file.sv
src/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
src/mem_wb_stage.sv
src/rv_core.sv
testbench/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f vlog.f
./obj_dir/Vtb_rv_core | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0
